/* source/evrPkg.sv */
// shared constants for a 125 MHz evrClk; stretch lengths follow evrClockRate, so change it there
package evrPkg;

    //////////////////////////////
    // clock and word format
    localparam int evrClockRate = 125000000;     // evrClk in Hz
    localparam int rxWordWidth  = 16;            // two decoded bytes per word
    localparam int codeWidth    = 8;             // event code is the low byte

    //////////////////////////////
    // special characters and codes
    localparam logic [codeWidth-1:0] commaChar     = 8'hBC;  // K28.5
    localparam logic [codeWidth-1:0] heartbeatCode = 8'd122;

    //////////////////////////////
    // alignment
    // clean commas in a row before the link counts as aligned
    localparam int commasNeeded    = 60;
    localparam int commaCountWidth = $clog2(commasNeeded + 1);   // must hold commasNeeded

    //////////////////////////////
    // marker lengths
    // heartbeat marker lasts a third of a second, long enough to see on a LED
    localparam int hbStretchCycles  = evrClockRate / 3;
    // pps marker of half a microsecond, 62 cycles at 125 MHz
    localparam int ppsStretchCycles = evrClockRate / 2000000;

    // receiver alignment state
    typedef enum logic {
        HUNT    = 1'b0,   // counting commas
        ALIGNED = 1'b1    // commas ignored, errors drop back
    } alignStateT;

endpackage

/* source/commaCounter.sv */
// counts down from commasNeeded; the caller must pulse reload_i after an alignment before reuse
`timescale 1ns/1ps

module commaCounter (
    input  logic evrClk,
    input  logic arstN_i,
    input  logic reload_i,        // error word seen, start over
    input  logic countEnable_i,   // clean comma while hunting
    output logic commasDone_o     // last comma is on the input now
);

    //////////////////////////////
    // counter
    localparam logic [evrPkg::commaCountWidth-1:0] reloadValue =
        evrPkg::commaCountWidth'(evrPkg::commasNeeded);
    localparam logic [evrPkg::commaCountWidth-1:0] lastComma =
        evrPkg::commaCountWidth'(1);

    logic [evrPkg::commaCountWidth-1:0] commasLeft;   // commas still missing

    always_ff @(posedge evrClk or negedge arstN_i) begin
        if (!arstN_i) begin
            commasLeft <= reloadValue;
        end else if (reload_i) begin
            commasLeft <= reloadValue;            // reload wins over a count
        end else if (countEnable_i) begin
            commasLeft <= commasLeft - lastComma;
        end
    end

    //////////////////////////////
    // done flag
    // combinational so the fsm changes state on the same edge
    // that takes the final comma
    always_comb begin
        commasDone_o = countEnable_i && (commasLeft == lastComma);
    end

endmodule

/* source/alignFsm.sv */
// slideRequest_i may be asynchronous; one bitSlide_o pulse per rising edge, three edges late
`timescale 1ns/1ps

module alignFsm (
    input  logic                        evrClk,
    input  logic                        arstN_i,
    input  logic [evrPkg::codeWidth-1:0] rxData_i,       // low byte only
    input  logic [1:0]                  rxIsK_i,
    input  logic [1:0]                  rxNotInTable_i,
    input  logic                        slideRequest_i, // async level
    input  logic                        commasDone_i,
    output logic                        reload_o,
    output logic                        countEnable_o,
    output logic                        rxAligned_o,
    output logic                        bitSlide_o
);

    //////////////////////////////
    // word classification
    logic isError;   // decode error or K in upper byte
    logic isComma;   // clean K28.5 in the low byte

    always_comb begin
        isError = (rxNotInTable_i != 2'b00) || rxIsK_i[1];
        isComma = rxIsK_i[0] && (rxData_i == evrPkg::commaChar) && !isError;
    end

    //////////////////////////////
    // hunt / aligned state machine
    evrPkg::alignStateT alignState;

    always_ff @(posedge evrClk or negedge arstN_i) begin
        if (!arstN_i) begin
            alignState <= evrPkg::HUNT;
        end else if (isError) begin
            alignState <= evrPkg::HUNT;           // any error drops lock
        end else if ((alignState == evrPkg::HUNT) && commasDone_i) begin
            alignState <= evrPkg::ALIGNED;
        end
    end

    always_comb begin
        reload_o      = isError;
        countEnable_o = isComma && (alignState == evrPkg::HUNT);   // ignore commas once locked
        rxAligned_o   = (alignState == evrPkg::ALIGNED);
    end

    //////////////////////////////
    // bit slide request
    // two flops against metastability, then a rising edge detect
    logic slideMeta;     // first sync stage
    logic slideSync;     // second sync stage
    logic slideSyncDly;  // previous synced value

    always_ff @(posedge evrClk or negedge arstN_i) begin
        if (!arstN_i) begin
            slideMeta    <= 1'b0;
            slideSync    <= 1'b0;
            slideSyncDly <= 1'b0;
            bitSlide_o   <= 1'b0;
        end else begin
            slideMeta    <= slideRequest_i;
            slideSync    <= slideMeta;
            slideSyncDly <= slideSync;
            bitSlide_o   <= slideSync && !slideSyncDly;   // one cycle per rise
        end
    end

endmodule

/* source/eventDecoder.sv */
// codes pass only while aligned; heartbeat is flagged regardless, upper byte is not decoded
`timescale 1ns/1ps

module eventDecoder (
    input  logic                           evrClk,
    input  logic                           arstN_i,
    input  logic [evrPkg::rxWordWidth-1:0] rxData_i,
    input  logic [1:0]                     rxIsK_i,
    input  logic                           rxAligned_i,
    output logic [evrPkg::codeWidth-1:0]   evrCode_o,
    output logic                           evrCodeValid_o,
    output logic                           hbSeen_o        // combinational pulse
);

    logic [evrPkg::codeWidth-1:0] codeByte;
    logic                         goodCode;

    always_comb begin
        codeByte = rxData_i[evrPkg::codeWidth-1:0];
        // zero is the idle code and K chars are not events
        goodCode = rxAligned_i && (codeByte != '0) && !rxIsK_i[0];
        // heartbeat does not wait for alignment
        hbSeen_o = (codeByte == evrPkg::heartbeatCode) && !rxIsK_i[0];
    end

    //////////////////////////////
    // registered code output
    always_ff @(posedge evrClk or negedge arstN_i) begin
        if (!arstN_i) begin
            evrCode_o      <= '0;
            evrCodeValid_o <= 1'b0;
        end else begin
            evrCode_o      <= goodCode ? codeByte : '0;   // code 0 when nothing valid
            evrCodeValid_o <= goodCode;
        end
    end

endmodule

/* source/markerStretcher.sv */
// stretchCycles must be positive; a trigger during the marker restarts the full length
`timescale 1ns/1ps

module markerStretcher #(
    parameter int stretchCycles = 1   // marker length in evrClk cycles
) (
    input  logic evrClk,
    input  logic arstN_i,
    input  logic trigger_i,
    output logic marker_o
);

    //////////////////////////////
    // negative-loaded up-counter
    // one extra bit so -stretchCycles has its sign bit set
    localparam int counterWidth = $clog2(stretchCycles + 1) + 1;
    localparam logic [counterWidth-1:0] reloadValue = counterWidth'(-stretchCycles);
    localparam logic [counterWidth-1:0] stepValue   = counterWidth'(1);

    logic [counterWidth-1:0] stretchCount;

    always_ff @(posedge evrClk or negedge arstN_i) begin
        if (!arstN_i) begin
            stretchCount <= '0;                     // idle, marker low
        end else if (trigger_i) begin
            stretchCount <= reloadValue;
        end else if (marker_o) begin
            stretchCount <= stretchCount + stepValue;   // stops at zero
        end
    end

    // high while count is negative
    always_comb begin
        marker_o = stretchCount[counterWidth-1];
    end

endmodule

/* source/evrReceiver.sv */
// receive fabric only; all inputs must already be in the evrClk domain except slideRequest_i
`timescale 1ns/1ps

module evrReceiver (
    input  logic                           evrClk,
    input  logic                           arstN_i,
    // decoded word stream, valid every cycle
    input  logic [evrPkg::rxWordWidth-1:0] rxData_i,
    input  logic [1:0]                     rxIsK_i,
    input  logic [1:0]                     rxNotInTable_i,
    input  logic                           ppsStrobe_i,    // one-cycle pulse
    input  logic                           slideRequest_i, // async level
    // event and status outputs
    output logic [evrPkg::codeWidth-1:0]   evrCode_o,
    output logic                           evrCodeValid_o,
    output logic                           rxAligned_o,
    output logic                           bitSlide_o,
    output logic                           hbMarker_o,
    output logic                           ppsMarker_o
);

    logic reload;       // error, restart comma count
    logic countEnable;  // clean comma while hunting
    logic commasDone;
    logic hbSeen;       // heartbeat code on the input

    //////////////////////////////
    // alignment
    alignFsm alignFsm (
        .evrClk         (evrClk),
        .arstN_i        (arstN_i),
        .rxData_i       (rxData_i[evrPkg::codeWidth-1:0]),
        .rxIsK_i        (rxIsK_i),
        .rxNotInTable_i (rxNotInTable_i),
        .slideRequest_i (slideRequest_i),
        .commasDone_i   (commasDone),
        .reload_o       (reload),
        .countEnable_o  (countEnable),
        .rxAligned_o    (rxAligned_o),
        .bitSlide_o     (bitSlide_o)
    );

    commaCounter commaCounter (
        .evrClk        (evrClk),
        .arstN_i       (arstN_i),
        .reload_i      (reload),
        .countEnable_i (countEnable),
        .commasDone_o  (commasDone)
    );

    //////////////////////////////
    // event codes
    eventDecoder eventDecoder (
        .evrClk         (evrClk),
        .arstN_i        (arstN_i),
        .rxData_i       (rxData_i),
        .rxIsK_i        (rxIsK_i),
        .rxAligned_i    (rxAligned_o),
        .evrCode_o      (evrCode_o),
        .evrCodeValid_o (evrCodeValid_o),
        .hbSeen_o       (hbSeen)
    );

    //////////////////////////////
    // markers
    markerStretcher #(.stretchCycles(evrPkg::hbStretchCycles)) hbStretcher (
        .evrClk    (evrClk),
        .arstN_i   (arstN_i),
        .trigger_i (hbSeen),
        .marker_o  (hbMarker_o)
    );

    markerStretcher #(.stretchCycles(evrPkg::ppsStretchCycles)) ppsStretcher (
        .evrClk    (evrClk),
        .arstN_i   (arstN_i),
        .trigger_i (ppsStrobe_i),
        .marker_o  (ppsMarker_o)
    );

endmodule

/* sim/evrReceiver_assertions.sv */
// bound into evrReceiver; all properties are off while arstN_i is low
`timescale 1ns/1ps

module evrReceiver_assertions (
    input logic                         evrClk,
    input logic                         arstN_i,
    input logic [1:0]                   rxIsK_i,
    input logic [1:0]                   rxNotInTable_i,
    input logic                         ppsStrobe_i,
    input logic [evrPkg::codeWidth-1:0] evrCode_i,       // DUT evrCode_o
    input logic                         evrCodeValid_i,
    input logic                         rxAligned_i,
    input logic                         bitSlide_i,
    input logic                         ppsMarker_i
);

    evrPkg::alignStateT linkState;   // rebuilt from the aligned flag
    logic               wordError;   // decode error or upper-byte K

    always_comb begin
        linkState = rxAligned_i ? evrPkg::ALIGNED : evrPkg::HUNT;
        wordError = (rxNotInTable_i != 2'b00) || rxIsK_i[1];
    end

    //////////////////////////////
    // output properties
    codeNonZero: assert property (@(posedge evrClk) disable iff (!arstN_i)
        evrCodeValid_i |-> (evrCode_i != '0))
        else $error("valid strobe with a zero event code");

    slideSinglePulse: assert property (@(posedge evrClk) disable iff (!arstN_i)
        bitSlide_i |=> !bitSlide_i)
        else $error("bitSlide held high for two cycles");

    errorDropsLock: assert property (@(posedge evrClk) disable iff (!arstN_i)
        wordError |=> (linkState == evrPkg::HUNT))
        else $error("receiver still aligned after an error word");

    ppsRaisesMarker: assert property (@(posedge evrClk) disable iff (!arstN_i)
        ppsStrobe_i |=> ppsMarker_i)
        else $error("pps strobe did not raise the pps marker");

endmodule

/* sim/tbEvrReceiver.sv */
// fixed seed 65884; the run is far shorter than hbStretchCycles so hbMarker never falls
`timescale 1ns/1ps

module tbEvrReceiver;

    //////////////////////////////
    // run length
    localparam int clkPeriod    = 8;      // ns
    localparam int resetCycles  = 5;
    localparam int alignCycles  = 300;    // directed comma runs
    localparam int lossCycles   = 1000;
    localparam int codeCycles   = 1600;
    localparam int ppsCycles    = 700;
    localparam int slideCycles  = 500;
    localparam int hbCycles     = 300;
    localparam int marginCycles = 500;
    localparam int watchdogNs   = (resetCycles + alignCycles + lossCycles + codeCycles
                                   + ppsCycles + slideCycles + hbCycles + marginCycles)
                                  * clkPeriod;

    logic                           evrClk;
    logic                           arstN;
    logic [evrPkg::rxWordWidth-1:0] rxData;
    logic [1:0]                     rxIsK;
    logic [1:0]                     rxNotInTable;
    logic                           ppsStrobe;
    logic                           slideRequest;
    logic [evrPkg::codeWidth-1:0]   evrCode;
    logic                           evrCodeValid;
    logic                           rxAligned;
    logic                           bitSlide;
    logic                           hbMarker;
    logic                           ppsMarker;

    int    seed;
    int    errorCount;
    int    highCycles;
    bit    slideLevel;    // slide request level held across cycles
    string currentTest;

    // reference model state as seen after the last edge
    bit                           mAligned;
    int                           mCommasLeft;
    logic [evrPkg::codeWidth-1:0] mCode;
    bit                           mValid;
    int                           mPpsLeft;
    int                           mHbLeft;
    bit                           mMeta;
    bit                           mSync;
    bit                           mSyncDly;
    bit                           mBitSlide;

    evrReceiver DUT (
        .evrClk         (evrClk),
        .arstN_i        (arstN),
        .rxData_i       (rxData),
        .rxIsK_i        (rxIsK),
        .rxNotInTable_i (rxNotInTable),
        .ppsStrobe_i    (ppsStrobe),
        .slideRequest_i (slideRequest),
        .evrCode_o      (evrCode),
        .evrCodeValid_o (evrCodeValid),
        .rxAligned_o    (rxAligned),
        .bitSlide_o     (bitSlide),
        .hbMarker_o     (hbMarker),
        .ppsMarker_o    (ppsMarker)
    );

    bind evrReceiver evrReceiver_assertions assertions (
        .evrClk         (evrClk),
        .arstN_i        (arstN_i),
        .rxIsK_i        (rxIsK_i),
        .rxNotInTable_i (rxNotInTable_i),
        .ppsStrobe_i    (ppsStrobe_i),
        .evrCode_i      (evrCode_o),
        .evrCodeValid_i (evrCodeValid_o),
        .rxAligned_i    (rxAligned_o),
        .bitSlide_i     (bitSlide_o),
        .ppsMarker_i    (ppsMarker_o)
    );

    initial begin
        evrClk = 1'b0;
        forever #(clkPeriod / 2) evrClk = ~evrClk;
    end

    //////////////////////////////
    // helpers
    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (expected !== actual) begin
            errorCount++;
            $display("FAILED %s: expected %0d, actual %0d", name, expected, actual);
            $display("Regression failed");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    function automatic int nextRand(input int range);
        int r;
        r = $random(seed) & 32'h7fffffff;   // keep it positive
        return r % range;
    endfunction

    // one word per cycle driven just after the rising edge
    task automatic applyCycle(input logic [evrPkg::rxWordWidth-1:0] data,
                              input logic [1:0] isK, input logic [1:0] notInTable,
                              input logic pps);
        @(posedge evrClk);
        rxData       <= data;
        rxIsK        <= isK;
        rxNotInTable <= notInTable;
        ppsStrobe    <= pps;
        slideRequest <= slideLevel;
    endtask

    task automatic applyIdle();
        applyCycle('0, 2'b00, 2'b00, 1'b0);
    endtask

    task automatic sendCommas(input int count);
        repeat (count) applyCycle({8'h00, evrPkg::commaChar}, 2'b01, 2'b00, 1'b0);
    endtask

    // percentages pick the word class and the rest are plain random codes
    task automatic applyRandom(input int commaPct, input int errorPct, input int kPct,
                               input int zeroPct, input int ppsPct, input bit allowHb);
        logic [evrPkg::rxWordWidth-1:0] data;
        logic [1:0]                     isK;
        logic [1:0]                     notInTable;
        logic                           pps;
        int                             pick;
        pick       = nextRand(100);
        data       = 16'(nextRand(65536));
        isK        = 2'b00;
        notInTable = 2'b00;
        if (pick < commaPct) begin
            data[7:0] = evrPkg::commaChar;
            isK       = 2'b01;
        end else if (pick < commaPct + errorPct) begin
            if (nextRand(2) == 0) begin
                notInTable = 2'(1 + nextRand(3));    // one or both bytes bad
            end else begin
                isK = 2'b10 | 2'(nextRand(2));        // upper-byte K
            end
        end else if (pick < commaPct + errorPct + kPct) begin
            isK = 2'b01;                              // K char and not an event
        end else if (pick < commaPct + errorPct + kPct + zeroPct) begin
            data[7:0] = '0;                           // idle code
        end
        // heartbeat held back until its own phase
        if (!allowHb && (data[7:0] == evrPkg::heartbeatCode)) begin
            data[7:0] = evrPkg::heartbeatCode + 8'd1;
        end
        pps = (nextRand(100) < ppsPct);
        applyCycle(data, isK, notInTable, pps);
    endtask

    task automatic countPpsHigh(output int count);
        count = 0;
        @(negedge evrClk);
        while (ppsMarker) begin
            count++;
            @(negedge evrClk);
        end
    endtask

    task automatic compareOutputs();
        checkValue({currentTest, ": rxAligned_o"}, 32'(mAligned), 32'(rxAligned));
        checkValue({currentTest, ": evrCode_o"}, 32'(mCode), 32'(evrCode));
        checkValue({currentTest, ": evrCodeValid_o"}, 32'(mValid), 32'(evrCodeValid));
        checkValue({currentTest, ": bitSlide_o"}, 32'(mBitSlide), 32'(bitSlide));
        checkValue({currentTest, ": ppsMarker_o"}, 32'(mPpsLeft > 0), 32'(ppsMarker));
        checkValue({currentTest, ": hbMarker_o"}, 32'(mHbLeft > 0), 32'(hbMarker));
    endtask

    //////////////////////////////
    // reference model
    // inputs are stable at the falling edge so step to what the next rise produces
    always @(negedge evrClk) begin : refModel
        logic                         isError;
        logic                         isComma;
        logic                         goodCode;
        logic                         isBeat;
        logic [evrPkg::codeWidth-1:0] codeByte;
        if (arstN !== 1'b1) begin
            mAligned    = 1'b0;
            mCommasLeft = evrPkg::commasNeeded;
            mCode       = '0;
            mValid      = 1'b0;
            mPpsLeft    = 0;
            mHbLeft     = 0;
            mMeta       = 1'b0;
            mSync       = 1'b0;
            mSyncDly    = 1'b0;
            mBitSlide   = 1'b0;
        end else begin
            compareOutputs();
            codeByte = rxData[7:0];
            isError  = (rxNotInTable != 2'b00) || rxIsK[1];
            isComma  = rxIsK[0] && (codeByte == evrPkg::commaChar) && !isError;
            goodCode = mAligned && (codeByte != 8'h00) && !rxIsK[0];   // pre-edge lock
            isBeat   = (codeByte == evrPkg::heartbeatCode) && !rxIsK[0];
            mCode    = goodCode ? codeByte : 8'h00;
            mValid   = goodCode;
            if (isError) begin
                mAligned    = 1'b0;
                mCommasLeft = evrPkg::commasNeeded;
            end else if (!mAligned && isComma) begin
                if (mCommasLeft == 1) begin
                    mAligned = 1'b1;         // same edge as the last comma
                end
                mCommasLeft = mCommasLeft - 1;
            end
            if (ppsStrobe) begin
                mPpsLeft = evrPkg::ppsStretchCycles;
            end else if (mPpsLeft > 0) begin
                mPpsLeft = mPpsLeft - 1;
            end
            if (isBeat) begin
                mHbLeft = evrPkg::hbStretchCycles;
            end else if (mHbLeft > 0) begin
                mHbLeft = mHbLeft - 1;
            end
            mBitSlide = mSync && !mSyncDly;   // rise of the synced level
            mSyncDly  = mSync;
            mSync     = mMeta;
            mMeta     = slideRequest;
        end
    end

    initial begin
        #(watchdogNs);
        $display("watchdog: run did not finish within %0d ns", watchdogNs);
        $display("Regression failed");
        $fatal(1, "timeout");
    end

    //////////////////////////////
    // test sequence
    initial begin
        seed         = 65884;
        errorCount   = 0;
        slideLevel   = 1'b0;
        currentTest  = "reset";
        arstN        = 1'b0;
        rxData       = '0;
        rxIsK        = 2'b00;
        rxNotInTable = 2'b00;
        ppsStrobe    = 1'b0;
        slideRequest = 1'b0;
        repeat (resetCycles) @(posedge evrClk);
        arstN <= 1'b1;

        // runs cut by both error kinds and then exactly commasNeeded
        currentTest = "alignment";
        sendCommas(40);
        applyCycle('0, 2'b00, 2'b01, 1'b0);
        sendCommas(40);
        applyCycle({8'h00, evrPkg::commaChar}, 2'b11, 2'b00, 1'b0);
        sendCommas(evrPkg::commasNeeded - 1);
        sendCommas(1);
        @(negedge evrClk);
        checkValue("alignment: before last comma", 0, 32'(rxAligned));
        applyIdle();
        @(negedge evrClk);
        checkValue("alignment: after last comma", 1, 32'(rxAligned));

        currentTest = "loss of alignment";
        applyCycle(16'h1234, 2'b00, 2'b10, 1'b0);
        applyIdle();
        @(negedge evrClk);
        checkValue("loss of alignment: after error", 0, 32'(rxAligned));
        sendCommas(evrPkg::commasNeeded - 1);
        applyIdle();
        applyIdle();
        @(negedge evrClk);
        checkValue("loss of alignment: one comma short", 0, 32'(rxAligned));
        sendCommas(1);
        applyIdle();
        @(negedge evrClk);
        checkValue("loss of alignment: realigned", 1, 32'(rxAligned));
        repeat (800) applyRandom(60, 2, 5, 5, 0, 1'b0);

        currentTest = "event codes";
        sendCommas(evrPkg::commasNeeded);
        repeat (1400) applyRandom(15, 1, 10, 10, 0, 1'b0);

        currentTest = "pps marker";
        applyCycle('0, 2'b00, 2'b00, 1'b1);
        applyIdle();
        countPpsHigh(highCycles);
        checkValue("pps marker: length", evrPkg::ppsStretchCycles, highCycles);
        applyCycle('0, 2'b00, 2'b00, 1'b1);
        repeat (21) applyIdle();
        applyCycle('0, 2'b00, 2'b00, 1'b1);   // mid-pulse retrigger
        applyIdle();
        countPpsHigh(highCycles);
        checkValue("pps marker: retrigger length", evrPkg::ppsStretchCycles, highCycles);
        repeat (400) applyRandom(20, 1, 5, 5, 3, 1'b0);

        currentTest = "bit slide";
        slideLevel = 1'b1;
        repeat (3) applyIdle();
        @(negedge evrClk);
        checkValue("bit slide: before third edge", 0, 32'(bitSlide));
        applyIdle();
        @(negedge evrClk);
        checkValue("bit slide: third edge", 1, 32'(bitSlide));
        applyIdle();
        @(negedge evrClk);
        checkValue("bit slide: single pulse", 0, 32'(bitSlide));
        slideLevel = 1'b0;
        repeat (400) begin
            if (nextRand(8) == 0) begin
                slideLevel = !slideLevel;
            end
            applyRandom(20, 1, 5, 5, 2, 1'b0);
        end

        // heartbeat last since its marker outlives the run
        currentTest = "heartbeat marker";
        @(negedge evrClk);
        checkValue("heartbeat marker: idle", 0, 32'(hbMarker));
        applyCycle('0, 2'b00, 2'b01, 1'b0);
        applyCycle({8'h00, evrPkg::heartbeatCode}, 2'b00, 2'b00, 1'b0);
        @(negedge evrClk);
        checkValue("heartbeat marker: before edge", 0, 32'(hbMarker));
        applyIdle();
        @(negedge evrClk);
        checkValue("heartbeat marker: hunting", 0, 32'(rxAligned));
        checkValue("heartbeat marker: raised", 1, 32'(hbMarker));
        repeat (200) applyRandom(20, 2, 5, 5, 2, 1'b1);
        @(negedge evrClk);
        checkValue("heartbeat marker: held", 1, 32'(hbMarker));

        if (errorCount == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

/* build.f */
source/evrPkg.sv
source/commaCounter.sv
source/alignFsm.sv
source/eventDecoder.sv
source/markerStretcher.sv
source/evrReceiver.sv
sim/evrReceiver_assertions.sv
sim/tbEvrReceiver.sv

/* Makefile */
# Verilator build and run for the event receiver testbench
# override any variable on the command line, e.g. make TOP=tbEvrReceiver OBJ_DIR=build

VERILATOR ?= verilator
TOP       ?= tbEvrReceiver
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only -Wall --timing
PASS_MSG  ?= Regression passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# status comes from the search for the pass line, not from the simulator exit code
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^$(PASS_MSG)$$"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
